// ==== common/arcade_cfg.svh ====
// ==================================================
// Build-time sizes for the arcade IO front end
// Key FIFO depth must be a power of two, at least 2
// ==================================================

`ifndef ARCADE_CFG_SVH
`define ARCADE_CFG_SVH

// Number of key events the buffer can hold
`define ARCADE_KEY_FIFO_DEPTH 4

// Top bit index of the sigma-delta DAC input
// 15 gives a 16-bit sample built from four copies of the 4-bit game audio
`define ARCADE_DAC_MSB 15

`endif

// ==== common/key_pkg.sv ====
// ==================================================
// Key event types and PS/2 set 2 scan codes
// Only the ten keys the board uses are listed
// ==================================================

package key_pkg;

	// Order matters, the id doubles as button state index
	typedef enum logic [3:0] {
		KEY_UP     = 4'd0,
		KEY_DOWN   = 4'd1,
		KEY_LEFT   = 4'd2,
		KEY_RIGHT  = 4'd3,
		KEY_COIN   = 4'd4,
		KEY_START1 = 4'd5,
		KEY_START2 = 4'd6,
		KEY_FIRE1  = 4'd7,
		KEY_FIRE2  = 4'd8,
		KEY_FIRE3  = 4'd9
	} key_id_e;

	typedef struct packed {
		key_id_e id;
		logic    pressed; // 1 on make, 0 on break
	} key_event_t;

	// ==================================================
	// Scan codes, low byte of the menu core key word
	// ==================================================
	localparam logic [7:0] SC_UP    = 8'h75;
	localparam logic [7:0] SC_DOWN  = 8'h72;
	localparam logic [7:0] SC_LEFT  = 8'h6B;
	localparam logic [7:0] SC_RIGHT = 8'h74;
	localparam logic [7:0] SC_ESC   = 8'h76; // Coin
	localparam logic [7:0] SC_F1    = 8'h05; // Start 1
	localparam logic [7:0] SC_F2    = 8'h06; // Start 2
	localparam logic [7:0] SC_CTRL  = 8'h14; // Fire 3
	localparam logic [7:0] SC_ALT   = 8'h11; // Fire 2
	localparam logic [7:0] SC_SPACE = 8'h29; // Fire 1

endpackage

// ==== common/ctrl_pkg.sv ====
// ==================================================
// Joystick and player input types seen by the core
// Raw joystick is active high, core side active low
// ==================================================

package ctrl_pkg;

	// One state bit per recognized key
	localparam int NUM_BUTTONS = 10;

	// Raw joystick from the menu core, bit 0 is right
	typedef struct packed {
		logic [2:0] unused;
		logic       fire;
		logic       up;
		logic       down;
		logic       left;
		logic       right;
	} joy_t;

	// Active-low directions as the core samples them
	typedef struct packed {
		logic right;
		logic left;
		logic down;
		logic up;
	} dir_t;

	// The core takes the same directions twice
	typedef struct packed {
		dir_t hi;
		dir_t lo;
	} joy_pair_t;

	// Active-low player input vector, MSB first
	typedef struct packed {
		logic r_coin;
		logic c_coin;
		logic l_coin;
		logic test;
		logic cocktail;
		logic slam;
		logic start2;
		logic start1;
		logic fire2;
		logic fire1;
	} player_in_t;

endpackage

// ==== hdl/key_event_decoder.sv ====
// ==================================================
// Bit 10 of ps2_key_i toggles once per key event
// Unknown scan codes produce no strobe
// ==================================================

`timescale 1ns/100ps

module key_event_decoder (
	input  logic                  clk_24,
	input  logic                  reset_i,
	input  logic [10:0]           ps2_key_i,
	output logic                  ev_valid_o,
	output key_pkg::key_event_t   ev_o
);

	logic              toggle_q;
	logic              toggled;
	logic              hit;
	key_pkg::key_id_e  id;

	assign toggled = ps2_key_i[10] != toggle_q;

	// Scan code lookup
	always_comb begin
		hit = 1'b1;
		id  = key_pkg::KEY_UP;
		case (ps2_key_i[7:0])
			key_pkg::SC_UP:    id = key_pkg::KEY_UP;
			key_pkg::SC_DOWN:  id = key_pkg::KEY_DOWN;
			key_pkg::SC_LEFT:  id = key_pkg::KEY_LEFT;
			key_pkg::SC_RIGHT: id = key_pkg::KEY_RIGHT;
			key_pkg::SC_ESC:   id = key_pkg::KEY_COIN;
			key_pkg::SC_F1:    id = key_pkg::KEY_START1;
			key_pkg::SC_F2:    id = key_pkg::KEY_START2;
			key_pkg::SC_SPACE: id = key_pkg::KEY_FIRE1;
			key_pkg::SC_ALT:   id = key_pkg::KEY_FIRE2;
			key_pkg::SC_CTRL:  id = key_pkg::KEY_FIRE3;
			default:           hit = 1'b0;
		endcase
	end

	always_ff @(posedge clk_24) begin
		if (reset_i) begin
			toggle_q   <= ps2_key_i[10]; // No event for a toggle left over from before reset
			ev_valid_o <= 1'b0;
		end else begin
			ev_valid_o <= 1'b0;
			if (toggled) begin
				toggle_q   <= ps2_key_i[10];
				ev_valid_o <= hit;
			end
		end
	end

	// Event payload, only meaningful with the strobe
	always_ff @(posedge clk_24) begin
		if (toggled) begin
			ev_o.id      <= id;
			ev_o.pressed <= ps2_key_i[9];
		end
	end

endmodule

// ==== hdl/key_event_fifo.sv ====
// ==================================================
// Key event FIFO, no back-pressure to the writer
// A write into a full buffer is lost, overflow sticks
// ==================================================

`timescale 1ns/100ps

`include "arcade_cfg.svh"

module key_event_fifo (
	input  logic                  clk_24,
	input  logic                  reset_i,
	input  logic                  wr_i,
	input  key_pkg::key_event_t   wr_data_i,
	input  logic                  pop_i,
	output key_pkg::key_event_t   head_o,
	output logic                  not_empty_o,
	output logic                  overflow_o
);

	localparam int DEPTH = `ARCADE_KEY_FIFO_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);

	key_pkg::key_event_t mem [DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0]   count;
	logic             full;
	logic             do_wr;
	logic             do_pop;

	assign full   = count == (PTR_W+1)'(DEPTH);
	assign do_wr  = wr_i && !full;
	assign do_pop = pop_i && not_empty_o;

	assign not_empty_o = count != '0;
	assign head_o      = mem[rd_ptr];

	// ==================================================
	// Pointers, fill level and overflow
	// ==================================================
	always_ff @(posedge clk_24) begin
		if (reset_i) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			count      <= '0;
			overflow_o <= 1'b0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1; // Wraps, depth is a power of two
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_wr, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			if (wr_i && full)
				overflow_o <= 1'b1; // Event dropped
		end
	end

	// Storage
	always_ff @(posedge clk_24) begin
		if (do_wr)
			mem[wr_ptr] <= wr_data_i;
	end

endmodule

// ==== hdl/control_mapper.sv ====
// ==================================================
// Button state, joystick merge and rotation swap
// Outputs active low and registered
// ==================================================

`timescale 1ns/100ps

module control_mapper (
	input  logic                   clk_24,
	input  logic                   reset_i,
	input  logic                   not_empty_i,
	input  key_pkg::key_event_t    head_i,
	output logic                   pop_o,
	input  ctrl_pkg::joy_t         joystick_0_i,
	input  ctrl_pkg::joy_t         joystick_1_i,
	input  logic                   rotate_i,
	input  logic                   test_i,
	output ctrl_pkg::player_in_t   playerinput_o,
	output ctrl_pkg::joy_pair_t    joystick_o
);

	logic [ctrl_pkg::NUM_BUTTONS-1:0] btn_q;
	logic [ctrl_pkg::NUM_BUTTONS-1:0] btn_d;

	logic act_up;
	logic act_down;
	logic act_left;
	logic act_right;

	ctrl_pkg::dir_t       dir_d;
	ctrl_pkg::player_in_t pin_d;

	// Take one event per cycle whenever there is one
	assign pop_o = not_empty_i;

	always_comb begin
		btn_d = btn_q;
		if (pop_o)
			btn_d[head_i.id] = head_i.pressed;
	end

	// ==================================================
	// Direction merge, keyboard or either stick
	// ==================================================
	always_comb begin
		act_up    = btn_d[key_pkg::KEY_UP]    | joystick_0_i.up    | joystick_1_i.up;
		act_down  = btn_d[key_pkg::KEY_DOWN]  | joystick_0_i.down  | joystick_1_i.down;
		act_left  = btn_d[key_pkg::KEY_LEFT]  | joystick_0_i.left  | joystick_1_i.left;
		act_right = btn_d[key_pkg::KEY_RIGHT] | joystick_0_i.right | joystick_1_i.right;
	end

	always_comb begin
		if (rotate_i) begin
			dir_d.up    = ~act_up;
			dir_d.down  = ~act_down;
			dir_d.left  = ~act_left;
			dir_d.right = ~act_right;
		end else begin
			// Screen turned a quarter, controls follow
			dir_d.up    = ~act_right;
			dir_d.down  = ~act_left;
			dir_d.left  = ~act_up;
			dir_d.right = ~act_down;
		end
	end

	// Player inputs, unused ones held inactive
	always_comb begin
		pin_d        = '1;
		pin_d.fire1  = ~(btn_d[key_pkg::KEY_FIRE1] | joystick_0_i.fire | joystick_1_i.fire);
		pin_d.c_coin = ~btn_d[key_pkg::KEY_COIN];
		pin_d.start1 = ~btn_d[key_pkg::KEY_START1];
		pin_d.test   = ~test_i;
	end

	// ==================================================
	// State and output registers
	// ==================================================
	always_ff @(posedge clk_24) begin
		if (reset_i) begin
			btn_q         <= '0; // All released
			playerinput_o <= '1;
			joystick_o    <= '1;
		end else begin
			btn_q         <= btn_d;
			playerinput_o <= pin_d;
			joystick_o.hi <= dir_d;
			joystick_o.lo <= dir_d;
		end
	end

endmodule

// ==== hdl/audio_dac.sv ====
// ==================================================
// First-order sigma-delta DAC, 1-bit output
// Needs an analog low-pass filter on the pin
// ==================================================

`timescale 1ns/100ps

`include "arcade_cfg.svh"

module audio_dac (
	input  logic                       clk_24,
	input  logic                       reset_i,
	input  logic [`ARCADE_DAC_MSB:0]   dac_i,
	output logic                       dac_o
);

	localparam int MSB = `ARCADE_DAC_MSB;

	logic [MSB+1:0] acc_q; // Top bit holds the last carry
	logic [MSB+1:0] sum;

	// Carry is dropped before the next add
	assign sum = {1'b0, acc_q[MSB:0]} + {1'b0, dac_i};

	always_ff @(posedge clk_24) begin
		if (reset_i)
			acc_q <= '0;
		else
			acc_q <= sum;
	end

	// Pulse density follows the input value
	assign dac_o = acc_q[MSB+1];

endmodule

// ==== hdl/arcade_io_top.sv ====
// ==================================================
// Keyboard, joystick and sound front end of the port
// ps2_key_i as delivered by the menu core, 11 bits
// ==================================================

`timescale 1ns/100ps

`include "arcade_cfg.svh"

module arcade_io_top (
	input  logic                   clk_24,
	input  logic                   reset_i,
	input  logic [10:0]            ps2_key_i,
	input  ctrl_pkg::joy_t         joystick_0_i,
	input  ctrl_pkg::joy_t         joystick_1_i,
	input  logic                   rotate_i,
	input  logic                   test_i,
	input  logic [3:0]             audio_i,
	output ctrl_pkg::player_in_t   playerinput_o,
	output ctrl_pkg::joy_pair_t    joystick_o,
	output logic                   audio_o,
	output logic                   overflow_o
);

	localparam int DAC_W = `ARCADE_DAC_MSB + 1;

	logic                 ev_valid;
	key_pkg::key_event_t  ev;
	logic                 not_empty;
	key_pkg::key_event_t  head;
	logic                 pop;
	logic [DAC_W-1:0]     dac_in;

	// ==================================================
	// Key path
	// ==================================================
	key_event_decoder u_key_event_decoder (
		.clk_24     (clk_24),
		.reset_i    (reset_i),
		.ps2_key_i  (ps2_key_i),
		.ev_valid_o (ev_valid),
		.ev_o       (ev)
	);

	key_event_fifo u_key_event_fifo (
		.clk_24      (clk_24),
		.reset_i     (reset_i),
		.wr_i        (ev_valid),
		.wr_data_i   (ev),
		.pop_i       (pop),
		.head_o      (head),
		.not_empty_o (not_empty),
		.overflow_o  (overflow_o)
	);

	control_mapper u_control_mapper (
		.clk_24        (clk_24),
		.reset_i       (reset_i),
		.not_empty_i   (not_empty),
		.head_i        (head),
		.pop_o         (pop),
		.joystick_0_i  (joystick_0_i),
		.joystick_1_i  (joystick_1_i),
		.rotate_i      (rotate_i),
		.test_i        (test_i),
		.playerinput_o (playerinput_o),
		.joystick_o    (joystick_o)
	);

	// ==================================================
	// Sound, 4-bit sample stretched to full scale
	// ==================================================
	assign dac_in = {(DAC_W/4){audio_i}};

	audio_dac u_audio_dac (
		.clk_24  (clk_24),
		.reset_i (reset_i),
		.dac_i   (dac_in),
		.dac_o   (audio_o)
	);

endmodule

// ==== tb/arcade_io_sva.sv ====
// ==================================================
// Concurrent checks bound into arcade_io_top
// fail_count is read by the testbench
// ==================================================

`timescale 1ns/100ps

module arcade_io_sva (
	input logic                 clk_24,
	input logic                 reset_i,
	input logic [10:0]          ps2_key_i,
	input logic                 ev_valid_i,
	input ctrl_pkg::player_in_t playerinput_i,
	input ctrl_pkg::joy_pair_t  joystick_i,
	input logic                 dac_bit_i,
	input logic                 overflow_i
);

	int fail_count = 0;

	// First cycle out of reset
	reset_values: assert property (@(posedge clk_24)
		$fell(reset_i) |-> (playerinput_i == '1 && joystick_i == '1 && !dac_bit_i && !overflow_i))
		else begin
			$error("outputs not at reset values after reset");
			fail_count++;
		end

	// One strobe per toggle of bit 10
	single_strobe: assert property (@(posedge clk_24) disable iff (reset_i)
		ev_valid_i && $stable(ps2_key_i[10]) |=> !ev_valid_i)
		else begin
			$error("key event strobe longer than one cycle");
			fail_count++;
		end

	overflow_sticky: assert property (@(posedge clk_24) disable iff (reset_i)
		overflow_i |=> overflow_i)
		else begin
			$error("overflow flag fell without reset");
			fail_count++;
		end

endmodule

bind arcade_io_top arcade_io_sva u_arcade_io_sva (
	.clk_24        (clk_24),
	.reset_i       (reset_i),
	.ps2_key_i     (ps2_key_i),
	.ev_valid_i    (ev_valid),
	.playerinput_i (playerinput_o),
	.joystick_i    (joystick_o),
	.dac_bit_i     (audio_o),
	.overflow_i    (overflow_o)
);

// ==== tb/arcade_io_tb.sv ====
// ==================================================
// Self-checking testbench for the arcade IO front end
// Overflow case stalls the mapper with a force
// ==================================================

`timescale 1ns/100ps

`include "arcade_cfg.svh"

module arcade_io_tb;

	localparam int DEPTH = `ARCADE_KEY_FIFO_DEPTH;
	localparam int DAC_W = `ARCADE_DAC_MSB + 1;

	logic                 clk_24 = 1'b0;
	logic                 reset_i;
	logic [10:0]          ps2_key;
	ctrl_pkg::joy_t       joy0;
	ctrl_pkg::joy_t       joy1;
	logic                 rotate;
	logic                 test;
	logic [3:0]           audio;
	ctrl_pkg::player_in_t playerinput;
	ctrl_pkg::joy_pair_t  joystick;
	logic                 audio_bit;
	logic                 overflow;
	logic [9:0]           btn_model; // Expected pressed state per key id

	arcade_io_top u_arcade_io_top (
		.clk_24        (clk_24),
		.reset_i       (reset_i),
		.ps2_key_i     (ps2_key),
		.joystick_0_i  (joy0),
		.joystick_1_i  (joy1),
		.rotate_i      (rotate),
		.test_i        (test),
		.audio_i       (audio),
		.playerinput_o (playerinput),
		.joystick_o    (joystick),
		.audio_o       (audio_bit),
		.overflow_o    (overflow)
	);

	always #2 clk_24 = ~clk_24;

	task automatic end_with_failure();
		$display("TEST FAILED");
		$fatal(1, "Run stopped at the first failure");
	endtask

	task automatic report_mismatch(input string msg);
		$display("FAILED at %0t ns: %s", $time, msg);
		end_with_failure();
	endtask

	task automatic report_timeout(input string what);
		$display("Timed out at %0t ns waiting for %s", $time, what);
		end_with_failure();
	endtask

	// A failed bound assertion ends the run at once
	always @(negedge clk_24) begin
		if (u_arcade_io_top.u_arcade_io_sva.fail_count != 0) begin
			$display("A bound assertion failed before %0t ns", $time);
			end_with_failure();
		end
	end

	// Scan code per key id
	function automatic logic [7:0] scan_code(input int id);
		case (id)
			key_pkg::KEY_UP:     return key_pkg::SC_UP;
			key_pkg::KEY_DOWN:   return key_pkg::SC_DOWN;
			key_pkg::KEY_LEFT:   return key_pkg::SC_LEFT;
			key_pkg::KEY_RIGHT:  return key_pkg::SC_RIGHT;
			key_pkg::KEY_COIN:   return key_pkg::SC_ESC;
			key_pkg::KEY_START1: return key_pkg::SC_F1;
			key_pkg::KEY_START2: return key_pkg::SC_F2;
			key_pkg::KEY_FIRE1:  return key_pkg::SC_SPACE;
			key_pkg::KEY_FIRE2:  return key_pkg::SC_ALT;
			default:             return key_pkg::SC_CTRL;
		endcase
	endfunction

	// ==================================================
	// Reference model of the active-low outputs
	// ==================================================
	function automatic ctrl_pkg::player_in_t exp_player();
		ctrl_pkg::player_in_t p;
		p        = '1;
		p.fire1  = ~(btn_model[key_pkg::KEY_FIRE1] | joy0.fire | joy1.fire);
		p.c_coin = ~btn_model[key_pkg::KEY_COIN];
		p.start1 = ~btn_model[key_pkg::KEY_START1];
		p.test   = ~test;
		return p;
	endfunction

	function automatic ctrl_pkg::joy_pair_t exp_joystick();
		logic up;
		logic down;
		logic left;
		logic right;
		ctrl_pkg::dir_t d;
		up    = btn_model[key_pkg::KEY_UP]    | joy0.up    | joy1.up;
		down  = btn_model[key_pkg::KEY_DOWN]  | joy0.down  | joy1.down;
		left  = btn_model[key_pkg::KEY_LEFT]  | joy0.left  | joy1.left;
		right = btn_model[key_pkg::KEY_RIGHT] | joy0.right | joy1.right;
		if (rotate) begin
			d.up    = ~up;
			d.down  = ~down;
			d.left  = ~left;
			d.right = ~right;
		end else begin
			d.up    = ~right; // Quarter turn swap
			d.down  = ~left;
			d.left  = ~up;
			d.right = ~down;
		end
		return {d, d};
	endfunction

	function automatic logic outputs_ok();
		return playerinput == exp_player() && joystick == exp_joystick();
	endfunction

	// ==================================================
	// Stimulus helpers
	// ==================================================
	task automatic send_key(input logic [7:0] code, input logic pressed);
		@(posedge clk_24);
		ps2_key <= {~ps2_key[10], pressed, 1'b0, code};
	endtask

	// Waits for a match, then the outputs must hold for 4 cycles
	task automatic wait_for_outputs(input int max_lat);
		int n;
		n = 0;
		do begin
			@(negedge clk_24);
			n++;
			if (n > 20)
				report_timeout("the outputs to follow the key model");
		end while (!outputs_ok());
		assert (n <= max_lat) else report_mismatch($sformatf("key latency of %0d cycles", n));
		repeat (4) begin
			@(negedge clk_24);
			assert (outputs_ok()) else report_mismatch("outputs moved after settling");
		end
	endtask

	// Distinct keys on consecutive cycles, only the first kept ones reach the model
	task automatic send_burst(input int count, input int kept);
		int start;
		int id;
		logic p;
		start = $urandom_range(9);
		for (int k = 0; k < count; k++) begin
			id = (start + 3 * k) % 10;
			p  = 1'($urandom());
			send_key(scan_code(id), p);
			if (k < kept)
				btn_model[id] = p;
		end
	endtask

	task automatic apply_reset();
		@(posedge clk_24);
		reset_i <= 1'b1;
		joy0    <= '0;
		joy1    <= '0;
		test    <= 1'b0;
		repeat (3) @(posedge clk_24);
		reset_i <= 1'b0;
		btn_model = '0;
	endtask

	task automatic check_density(input logic [3:0] value);
		int ones;
		int expected;
		@(posedge clk_24);
		audio <= value;
		@(posedge clk_24);
		ones     = 0;
		expected = int'({(DAC_W/4){value}});
		for (int c = 0; c < (1 << DAC_W); c++) begin
			@(negedge clk_24);
			ones += audio_bit;
		end
		assert (ones >= expected - 1 && ones <= expected + 1)
			else report_mismatch($sformatf("%0d ones for sample %0d", ones, expected));
	endtask

	// ==================================================
	// Test sequence
	// ==================================================
	initial begin
		int n;
		int id;
		void'($urandom(86));
		reset_i   = 1'b1;
		ps2_key   = '0;
		joy0      = '0;
		joy1      = '0;
		rotate    = 1'b1;
		test      = 1'b0;
		audio     = '0;
		btn_model = '0;
		repeat (3) @(posedge clk_24);
		reset_i <= 1'b0;

		// Single presses and releases, unknown codes in between
		for (int i = 0; i < 12; i++) begin
			id = $urandom_range(9);
			send_key(scan_code(id), 1'b1);
			btn_model[id] = 1'b1;
			wait_for_outputs(4);
			send_key(8'h1C + 8'(i), 1'($urandom()));
			wait_for_outputs(4);
			send_key(scan_code(id), 1'b0);
			btn_model[id] = 1'b0;
			wait_for_outputs(4);
		end

		// Joystick merge under both rotations, one key held
		send_key(scan_code(key_pkg::KEY_UP), 1'b1);
		btn_model[key_pkg::KEY_UP] = 1'b1;
		wait_for_outputs(4);
		for (int i = 0; i < 24; i++) begin
			@(posedge clk_24);
			joy0   <= 8'($urandom());
			joy1   <= 8'($urandom());
			rotate <= i[0];
			test   <= 1'($urandom());
			@(posedge clk_24);
			@(negedge clk_24);
			assert (outputs_ok()) else report_mismatch("joystick merge or rotation");
		end

		// Four queued events
		send_burst(4, 4);
		wait_for_outputs(8);
		assert (!overflow) else report_mismatch("overflow set by four queued events");

		// Overflow with the consumer stalled
		@(negedge clk_24);
		force u_arcade_io_top.u_control_mapper.not_empty_i = 1'b0;
		send_burst(DEPTH + 2, DEPTH);
		n = 0;
		while (!overflow) begin
			@(negedge clk_24);
			n++;
			if (n > 20)
				report_timeout("the overflow flag");
		end
		@(negedge clk_24);
		release u_arcade_io_top.u_control_mapper.not_empty_i;
		wait_for_outputs(8);
		assert (overflow) else report_mismatch("overflow fell without reset");
		apply_reset();
		@(negedge clk_24);
		assert (!overflow) else report_mismatch("overflow kept through reset");

		// Audio pulse density
		check_density(4'hF);
		for (int i = 0; i < 3; i++)
			check_density(4'($urandom()));

		if (u_arcade_io_top.u_arcade_io_sva.fail_count == 0) begin
			$display("TEST OK");
			$finish;
		end else begin
			end_with_failure();
		end
	end

endmodule

// ==== filelist.f ====
+incdir+common
common/key_pkg.sv
common/ctrl_pkg.sv
hdl/key_event_decoder.sv
hdl/key_event_fifo.sv
hdl/control_mapper.sv
hdl/audio_dac.sv
hdl/arcade_io_top.sv
tb/arcade_io_sva.sv
tb/arcade_io_tb.sv
